// File: rtl/bch_code_pkg.sv
`default_nettype none

package bch_code_pkg;

	// Smallest field order whose full length covers n.
	function automatic int n2m(input int n);
		int m;
		m = 1;
		while ((1 << m) - 1 < n)
			m++;
		return m;
	endfunction

	function automatic int parity_len(input int n, input int k);
		return n - k;
	endfunction

	// Product of the minimal polynomials of alpha^1 .. alpha^(2t-1).
	function automatic logic [(1 << bch_gf_pkg::MAX_M)-1:0] generator_poly(input int m,
			input int t);
		logic [(1 << bch_gf_pkg::MAX_M)-1:0] gen;
		logic [(1 << bch_gf_pkg::MAX_M)-1:0] prod;
		logic [bch_gf_pkg::MAX_M-1:0] minp [0:bch_gf_pkg::MAX_M];
		logic [bch_gf_pkg::MAX_M-1:0] root;
		logic [bch_gf_pkg::MAX_M-1:0] conj;
		logic done;
		int n;
		int s;
		int next_s;
		int deg;
		int i;
		n = (1 << m) - 1;
		gen = 1;
		s = 1;
		root = 2;	// Alpha.
		while (s <= 2 * t - 1 && s < n) begin
			for (i = 0; i <= bch_gf_pkg::MAX_M; i++)
				minp[i] = '0;
			minp[0] = 1;
			deg = 0;
			conj = root;
			done = 1'b0;
			// Multiply in (x + c) for each conjugate c of the root.
			while (!done) begin
				for (i = deg + 1; i > 0; i--)
					minp[i] = minp[i-1] ^ bch_gf_pkg::gf_mul(m, minp[i], conj);
				minp[0] = bch_gf_pkg::gf_mul(m, minp[0], conj);
				deg++;
				conj = bch_gf_pkg::gf_mul(m, conj, conj);
				if (conj == root)
					done = 1'b1;
			end
			// Coefficients are now 0 or 1, so multiply over GF(2).
			prod = '0;
			for (i = 0; i <= deg; i++)
				if (minp[i][0])
					prod = prod ^ (gen << i);
			gen = prod;
			next_s = bch_gf_pkg::next_syndrome(m, s);
			for (i = s; i < next_s; i++)
				root = bch_gf_pkg::gf_mul1(m, root);
			s = next_s;
		end
		return gen;
	endfunction

endpackage

`default_nettype wire

// File: rtl/bch_codeword_collect.sv
`default_nettype none

module bch_codeword_collect #(
	parameter int N = 15
) (
	input logic clk,
	input logic reset,
	bch_frame_if.coll stream,
	output logic [N-1:0] codeword,
	output logic codeword_valid
);

	logic [N-1:0] assembly;
	logic [N-1:0] word;
	logic capture;

	// Word including the bit arriving this cycle.
	assign word = {assembly[N-2:0], stream.code_bit};

	assign capture = stream.frame_last & stream.payload;

	always_ff @(posedge clk) begin
		assembly <= word;
		if (capture)
			codeword <= word;	// Held until the next payload frame.
	end

	always_ff @(posedge clk) begin
		if (reset)
			codeword_valid <= 1'b0;
		else
			codeword_valid <= capture;
	end

endmodule

`default_nettype wire

// File: rtl/bch_encode.sv
`default_nettype none

module bch_encode #(
	parameter int N = 15,	// Codeword length.
	parameter int K = 5,	// Message length.
	parameter int T = 3	// Correctable errors.
) (
	input logic clk,
	input logic reset,
	input logic din,
	input logic payload_in,
	output logic vdin,
	output logic frame_end,
	bch_frame_if.enc stream
);

	localparam int M = bch_code_pkg::n2m(N);
	localparam int P = bch_code_pkg::parity_len(N, K);
	localparam logic [(1 << bch_gf_pkg::MAX_M)-1:0] GEN_FULL =
		bch_code_pkg::generator_poly(M, T);
	localparam logic [P-1:0] GEN = GEN_FULL[P-1:0];	// x^P term is implicit.
	localparam logic [M-1:0] POS_DATA_END = M'(bch_gf_pkg::lfsr_count(M, K - 1));
	localparam logic [M-1:0] POS_LAST = M'(bch_gf_pkg::lfsr_count(M, N - 1));

	logic [M-1:0] count;
	logic restart;
	logic feedback;
	logic [P-1:0] parity;

	assign frame_end = (count == POS_LAST);

	// Restarting at the last position keeps shortened codes at N cycles.
	assign restart = reset | frame_end;

	assign feedback = vdin & (din ^ parity[P-1]);

	lfsr_counter #(
		.M(M)
	) u_counter (
		.clk(clk),
		.reset(restart),
		.count(count)
	);

	// Data phase covers positions 0 to K-1.
	always_ff @(posedge clk) begin
		if (reset)
			vdin <= 1'b1;
		else if (count == POS_DATA_END)
			vdin <= 1'b0;
		else if (frame_end)
			vdin <= 1'b1;
	end

	// Division remainder; it empties itself during the parity phase.
	always_ff @(posedge clk) begin
		if (reset)
			parity <= '0;
		else
			parity <= (parity << 1) ^ ({P{feedback}} & GEN);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			stream.code_bit <= 1'b0;
			stream.data_phase <= 1'b0;
			stream.payload <= 1'b0;
			stream.frame_last <= 1'b0;
		end else begin
			stream.code_bit <= vdin ? din : parity[P-1];	// Systematic output.
			stream.data_phase <= vdin;
			stream.payload <= payload_in;
			stream.frame_last <= frame_end;
		end
	end

endmodule

`default_nettype wire

// File: rtl/bch_frame_if.sv
`default_nettype none

// Serial codeword stream with its frame markers.
interface bch_frame_if;
	logic code_bit;		// Encoded serial bit.
	logic data_phase;	// Message part of the frame.
	logic payload;		// Frame carries a loaded message.
	logic frame_last;	// Last bit of the frame.

	modport enc (
		output code_bit,
		output data_phase,
		output payload,
		output frame_last
	);

	modport coll (
		input code_bit,
		input data_phase,
		input payload,
		input frame_last
	);
endinterface

`default_nettype wire

// File: rtl/bch_gf_pkg.sv
`default_nettype none

package bch_gf_pkg;

	localparam int MAX_M = 16;	// Largest supported field order.

	// Primitive polynomial of GF(2^m), x^m term included.
	function automatic logic [MAX_M:0] prim_poly(input int m);
		case (m)
			2: return 17'h00007;
			3: return 17'h0000b;
			4: return 17'h00013;
			5: return 17'h00025;
			6: return 17'h00043;
			7: return 17'h00083;
			8: return 17'h0011d;
			9: return 17'h00211;
			10: return 17'h00409;
			11: return 17'h00805;
			12: return 17'h01053;
			13: return 17'h0201b;
			14: return 17'h04443;
			15: return 17'h08003;
			default: return 17'h1100b;
		endcase
	endfunction

	function automatic logic [MAX_M-1:0] gf_mul1(input int m, input logic [MAX_M-1:0] a);
		logic [MAX_M:0] t;
		t = {a, 1'b0};
		if (t[m])
			t = t ^ prim_poly(m);	// Reduce modulo the primitive polynomial.
		return t[MAX_M-1:0];
	endfunction

	function automatic logic [MAX_M-1:0] gf_mul(input int m, input logic [MAX_M-1:0] a,
			input logic [MAX_M-1:0] b);
		logic [MAX_M-1:0] acc;
		logic [MAX_M-1:0] x;
		int i;
		acc = '0;
		x = a;
		for (i = 0; i < m; i++) begin
			if (b[i])
				acc = acc ^ x;
			x = gf_mul1(m, x);
		end
		return acc;
	endfunction

	// Next odd index that leads its own cyclotomic coset.
	function automatic int next_syndrome(input int m, input int s);
		int n;
		int c;
		int r;
		int k;
		logic leader;
		logic found;
		n = (1 << m) - 1;
		found = 1'b0;
		c = s + 2;
		while (!found && c < n) begin
			leader = 1'b1;
			r = c;
			for (k = 1; k < m; k++) begin
				r = (r * 2) % n;
				if (r < c)
					leader = 1'b0;	// Conjugate of a smaller index.
			end
			if (leader)
				found = 1'b1;
			else
				c = c + 2;
		end
		return c;
	endfunction

	// Fibonacci tap mask, bit j taps register bit j.
	function automatic logic [MAX_M-1:0] lfsr_taps(input int m);
		logic [MAX_M:0] p;
		logic [MAX_M-1:0] taps;
		int i;
		p = prim_poly(m);
		taps = '0;
		for (i = 0; i < m; i++)
			taps[m-1-i] = p[i];
		return taps;
	endfunction

	function automatic logic [MAX_M-1:0] lfsr_count(input int m, input int steps);
		logic [MAX_M-1:0] s;
		logic [MAX_M-1:0] mask;
		int i;
		s = 1;	// Seed.
		mask = MAX_M'((1 << m) - 1);
		for (i = 0; i < steps; i++)
			s = ((s << 1) | MAX_M'(^(s & lfsr_taps(m)))) & mask;
		return s;
	endfunction

endpackage

`default_nettype wire

// File: rtl/bch_msg_loader.sv
`default_nettype none

module bch_msg_loader #(
	parameter int K = 5
) (
	input logic clk,
	input logic reset,
	input logic [K-1:0] msg,
	input logic msg_load,
	output logic msg_ready,
	input logic vdin,
	input logic frame_end,
	output logic din,
	output logic payload_in
);

	logic full;
	logic take;
	logic [K-1:0] held;
	logic [K-1:0] shifter;

	assign msg_ready = ~full;
	assign take = msg_load & ~full;	// Loads while full are dropped.

	// Idle frames send zeros.
	assign din = payload_in & shifter[K-1];

	always_ff @(posedge clk) begin
		if (reset) begin
			full <= 1'b0;
			payload_in <= 1'b0;
		end else if (frame_end) begin
			// A load in the last cycle goes straight to the shifter.
			payload_in <= full | take;
			full <= 1'b0;
		end else if (take) begin
			full <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			held <= msg;

		if (frame_end)
			shifter <= full ? held : msg;
		else if (vdin)
			shifter <= shifter << 1;	// MSB first.
	end

endmodule

`default_nettype wire

// File: rtl/bch_tx_top.sv
`default_nettype none

module bch_tx_top #(
	parameter int N = 15,
	parameter int K = 5,
	parameter int T = 3
) (
	input logic clk,
	input logic reset,
	input logic [K-1:0] msg,
	input logic msg_load,
	output logic msg_ready,
	output logic serial_out,
	output logic data_phase_out,
	output logic [N-1:0] codeword,
	output logic codeword_valid
);

	logic din;
	logic payload_in;
	logic vdin;
	logic frame_end;

	bch_frame_if stream ();

	bch_msg_loader #(
		.K(K)
	) u_loader (
		.clk(clk),
		.reset(reset),
		.msg(msg),
		.msg_load(msg_load),
		.msg_ready(msg_ready),
		.vdin(vdin),
		.frame_end(frame_end),
		.din(din),
		.payload_in(payload_in)
	);

	bch_encode #(
		.N(N),
		.K(K),
		.T(T)
	) u_encode (
		.clk(clk),
		.reset(reset),
		.din(din),
		.payload_in(payload_in),
		.vdin(vdin),
		.frame_end(frame_end),
		.stream(stream.enc)
	);

	bch_codeword_collect #(
		.N(N)
	) u_collect (
		.clk(clk),
		.reset(reset),
		.stream(stream.coll),
		.codeword(codeword),
		.codeword_valid(codeword_valid)
	);

	// Serial stream also goes out directly.
	assign serial_out = stream.code_bit;
	assign data_phase_out = stream.data_phase;

endmodule

`default_nettype wire

// File: rtl/lfsr_counter.sv
`default_nettype none

module lfsr_counter #(
	parameter int M = 4
) (
	input logic clk,
	input logic reset,
	output logic [M-1:0] count
);

	localparam logic [bch_gf_pkg::MAX_M-1:0] TAPS_FULL = bch_gf_pkg::lfsr_taps(M);
	localparam logic [M-1:0] TAPS = TAPS_FULL[M-1:0];
	localparam logic [M-1:0] SEED = M'(bch_gf_pkg::lfsr_count(M, 0));

	logic feedback;

	assign feedback = ^(count & TAPS);

	// Maximal length sequence, period 2^M-1.
	always_ff @(posedge clk) begin
		if (reset)
			count <= SEED;
		else
			count <= {count[M-2:0], feedback};
	end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds and runs the BCH encoder testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing -Wno-fatal --top-module bch_tb -f sim.f > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vbch_tb > sim.log 2>&1
cat sim.log

grep -qx "RESULT: PASS" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: sim.f
rtl/bch_gf_pkg.sv
rtl/bch_code_pkg.sv
rtl/bch_frame_if.sv
rtl/lfsr_counter.sv
rtl/bch_encode.sv
rtl/bch_msg_loader.sv
rtl/bch_codeword_collect.sv
rtl/bch_tx_top.sv
sim/bch_tb.sv

// File: sim/bch_tb.sv
`default_nettype none

module bch_tb;

	localparam int N = 15;
	localparam int K = 5;
	localparam int T = 3;
	localparam int M = bch_code_pkg::n2m(N);
	localparam int P = bch_code_pkg::parity_len(N, K);
	localparam logic [(1 << bch_gf_pkg::MAX_M)-1:0] GEN_FULL =
		bch_code_pkg::generator_poly(M, T);
	localparam logic [N-1:0] GEN = GEN_FULL[N-1:0];
	localparam int NUM_TESTS = 6;
	localparam int NUM_RANDOM = 200;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * NUM_RANDOM * 2 * N + 100;
	localparam int DRAIN_LIMIT = 3 * N + 10;	// Worst load to valid is 2N+2.

	logic clk;
	logic reset;
	logic [K-1:0] msg;
	logic msg_load;
	logic msg_ready;
	logic serial_out;
	logic data_phase_out;
	logic [N-1:0] codeword;
	logic codeword_valid;

	logic [N-1:0] exp_q [$];	// Expected words in load order.
	string test_name;
	int errors;
	int test_errors_at_start;
	int tests_run;
	int tests_failed;

	bch_tx_top #(
		.N(N),
		.K(K),
		.T(T)
	) DUT (
		.clk(clk),
		.reset(reset),
		.msg(msg),
		.msg_load(msg_load),
		.msg_ready(msg_ready),
		.serial_out(serial_out),
		.data_phase_out(data_phase_out),
		.codeword(codeword),
		.codeword_valid(codeword_valid)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Systematic encoding by long division of msg * x^P.
	function automatic logic [N-1:0] ref_codeword(input logic [K-1:0] value);
		logic [N-1:0] rem;
		int i;
		rem = {value, {P{1'b0}}};
		for (i = N - 1; i >= P; i--)
			if (rem[i])
				rem = rem ^ (GEN << (i - P));
		return {value, rem[P-1:0]};
	endfunction

	task automatic check_codeword(input string label, input logic [N-1:0] expected,
			input logic [N-1:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s %s: expected %h, actual %h", test_name, label, expected, actual);
			errors++;
		end
	endtask

	task automatic check_bit(input string label, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("FAIL %s %s: expected %b, actual %b", test_name, label, expected, actual);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors_at_start = errors;
	endtask

	task automatic end_test;
		tests_run++;
		if (errors == test_errors_at_start) begin
			$display("test %s: passed", test_name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", test_name, errors - test_errors_at_start);
		end
	endtask

	task automatic apply_reset;
		@(posedge clk);
		reset <= 1'b1;
		msg_load <= 1'b0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
	endtask

	// Waits for msg_ready, then pulses msg_load for one cycle.
	task automatic load_msg(input logic [K-1:0] value, input logic [N-1:0] expected,
			input logic keep);
		@(negedge clk);
		while (!msg_ready)
			@(negedge clk);
		@(posedge clk);
		msg <= value;
		msg_load <= 1'b1;
		if (keep)
			exp_q.push_back(expected);
		@(posedge clk);
		msg_load <= 1'b0;
	endtask

	// Returns at the negedge that shows the first bit of a frame.
	task automatic wait_frame_start;
		logic prev;
		do begin
			prev = data_phase_out;
			@(negedge clk);
		end while (!(data_phase_out && !prev));
	endtask

	task automatic wait_drain;
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (exp_q.size() != 0) begin
			$display("ERROR in %s: %0d codeword_valid pulses never arrived", test_name,
				exp_q.size());
			errors++;
			exp_q.delete();
		end
		@(negedge clk);
	endtask

	// Every valid pulse must match the oldest expected word.
	always @(negedge clk) begin
		if (codeword_valid) begin
			if (exp_q.size() == 0) begin
				$display("ERROR in %s: codeword_valid pulsed with no word expected", test_name);
				errors++;
			end else begin
				check_codeword("codeword", exp_q.pop_front(), codeword);
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin : main_seq
		logic [K-1:0] m;
		logic [N-1:0] word;
		int i;
		int n;
		reset = 1'b1;
		msg = '0;
		msg_load = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		test_name = "reset";
		void'($urandom(29));
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		start_test("generator and known words");
		check_codeword("generator", 15'h0537, GEN);
		check_bit("generator above degree N", 1'b0, |(GEN_FULL >> N));
		check_codeword("ref_codeword of 1", 15'h0537, ref_codeword(5'd1));
		load_msg(5'd0, 15'h0000, 1'b1);
		load_msg(5'd1, 15'h0537, 1'b1);
		wait_drain();
		end_test();

		start_test("random messages");
		for (n = 0; n < NUM_RANDOM; n++) begin
			m = K'($urandom());
			load_msg(m, ref_codeword(m), 1'b1);
		end
		wait_drain();
		end_test();

		start_test("serial stream");
		for (n = 0; n < 4; n++) begin
			m = K'($urandom());
			word = ref_codeword(m);
			wait_frame_start();
			load_msg(m, word, 1'b1);
			wait_frame_start();	// Payload frame.
			for (i = 0; i < N; i++) begin
				check_bit("serial_out", word[N-1-i], serial_out);
				check_bit("data_phase_out", i < K, data_phase_out);
				@(negedge clk);
			end
		end
		wait_drain();
		end_test();

		start_test("idle frames");
		for (i = 0; i < 4 * N; i++) begin
			check_bit("serial_out idle", 1'b0, serial_out);
			check_bit("codeword_valid idle", 1'b0, codeword_valid);
			@(negedge clk);
		end
		end_test();

		start_test("load refusal");
		m = K'($urandom());
		wait_frame_start();
		load_msg(~m, ref_codeword(~m), 1'b0);	// Buffer still full when reset comes.
		apply_reset();
		check_bit("msg_ready after reset", 1'b1, msg_ready);
		check_bit("codeword_valid after reset", 1'b0, codeword_valid);
		check_bit("serial_out after reset", 1'b0, serial_out);
		wait_frame_start();
		load_msg(m, ref_codeword(m), 1'b1);
		@(negedge clk);
		check_bit("msg_ready while full", 1'b0, msg_ready);
		@(posedge clk);
		msg <= ~m;	// Must be dropped.
		msg_load <= 1'b1;
		@(posedge clk);
		msg_load <= 1'b0;
		wait_drain();
		check_codeword("held codeword", ref_codeword(m), codeword);
		repeat (3 * N) @(negedge clk);
		end_test();

		start_test("reset mid-frame");
		m = K'($urandom());
		wait_frame_start();
		load_msg(m, ref_codeword(m), 1'b0);
		wait_frame_start();
		repeat (4) @(negedge clk);
		apply_reset();
		repeat (3 * N) @(negedge clk);	// A stray pulse is caught by the compare process.
		m = K'($urandom());
		load_msg(m, ref_codeword(m), 1'b1);
		wait_drain();
		end_test();

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
